// ==== design/cache_test_pkg.sv ====
// ============================
// Shared widths, opcodes, cache geometry and test constants for the
// cache-access test node. Modules import it with a wildcard import.
// ============================

package cache_test_pkg;

  localparam int data_width_c    = 32;
  localparam int addr_width_c    = 12;
  localparam int tag_space_bit_c = 10; // Set selects the tag array.

  typedef logic [data_width_c-1:0] word_t;
  typedef logic [addr_width_c-1:0] addr_t;

  typedef logic [1:0] op_t;
  localparam op_t op_load_c  = 2'd0;
  localparam op_t op_store_c = 2'd1;

  localparam int sets_c           = 4;
  localparam int ways_c           = 2;
  localparam int block_words_c    = 4;
  localparam int lg_block_words_c = $clog2(block_words_c);
  localparam int tag_entries_c    = sets_c * ways_c;
  typedef logic [$clog2(tag_entries_c)-1:0] tag_idx_t;

  localparam int num_test_word_c    = 16;
  localparam int lg_num_test_word_c = $clog2(num_test_word_c);
  typedef logic [lg_num_test_word_c-1:0] mem_idx_t;

  localparam int node_id_c     = 3;
  localparam int tag_offset_c  = 16; // Tag entry t holds t + 16.
  localparam int max_credits_c = 4;

  localparam int num_responses_c = tag_entries_c + num_test_word_c;

  typedef struct packed {
    op_t   op;
    addr_t addr;
    word_t payload;
  } req_s;

  typedef struct packed {
    word_t data;
  } resp_s;

endpackage

// ==== design/small_fifo.sv ====
// ============================
// Two-entry queue for any payload type. Write when ready_o is high,
// pop the head with a yumi_i pulse while v_o is high.
// ============================

module small_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,

  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,

  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  payload_t mem_r [0:1];
  logic     wr_ptr_r;
  logic     rd_ptr_r;
  logic     full_r;
  logic     empty;
  logic     enq;
  logic     deq;

  assign empty   = (wr_ptr_r == rd_ptr_r) & ~full_r;
  assign enq     = v_i & ~full_r;
  assign deq     = yumi_i & ~empty;

  assign ready_o = ~full_r;
  assign v_o     = ~empty;
  assign data_o  = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
    end else begin
      if (enq) wr_ptr_r <= ~wr_ptr_r;
      if (deq) rd_ptr_r <= ~rd_ptr_r;
      if (enq != deq) begin
        full_r <= enq & (wr_ptr_r != rd_ptr_r); // Pointers meet again on a write.
      end
    end
  end

endmodule

// ==== design/link_endpoint.sv ====
// ============================
// Link endpoint between the test master and the memory slave. Queues
// requests and responses and limits the requests in flight by credits.
// ============================

module link_endpoint
  import cache_test_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,

  // Requests out from the master.
  input  logic  out_v_i,
  input  req_s  out_req_i,
  output logic  out_ready_o,

  // Responses back to the master.
  output logic  returned_v_o,
  output word_t returned_data_o,
  input  logic  returned_yumi_i,

  // Requests to the slave and its responses and credits.
  output logic  req_v_o,
  output req_s  req_o,
  input  logic  req_yumi_i,

  input  logic  resp_v_i,
  input  resp_s resp_i,
  input  logic  credit_return_i
);

  localparam int credit_width_lp = $clog2(max_credits_c + 1);

  logic [credit_width_lp-1:0] credits_r;
  logic  req_fifo_ready;
  logic  out_xfer;
  resp_s resp_head;

  assign out_ready_o = req_fifo_ready & (credits_r < credit_width_lp'(max_credits_c));
  assign out_xfer    = out_v_i & out_ready_o;

  small_fifo #(
    .payload_t(req_s)
  ) req_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (out_xfer),
    .data_i (out_req_i),
    .ready_o(req_fifo_ready),
    .v_o    (req_v_o),
    .data_o (req_o),
    .yumi_i (req_yumi_i)
  );

  // The master pops every response as it shows, so this queue never
  // holds more than one entry.
  small_fifo #(
    .payload_t(resp_s)
  ) resp_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (resp_v_i),
    .data_i (resp_i),
    .ready_o(),
    .v_o    (returned_v_o),
    .data_o (resp_head),
    .yumi_i (returned_yumi_i)
  );

  assign returned_data_o = resp_head.data;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_r <= '0;
    end else begin
      case ({out_xfer, credit_return_i})
        2'b10:   credits_r <= credits_r + 1'b1; // New request in flight.
        2'b01:   credits_r <= credits_r - 1'b1; // Slave accepted one.
        default: credits_r <= credits_r;
      endcase
    end
  end

endmodule

// ==== design/tag_data_mem_slave.sv ====
// ============================
// Memory slave holding a small tag array and a word-addressed data
// memory. Address bit tag_space_bit_c picks the tag array.
// ============================

module tag_data_mem_slave
  import cache_test_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,

  input  logic  stall_i,

  input  logic  req_v_i,
  input  req_s  req_i,
  output logic  req_yumi_o,

  output logic  resp_v_o,
  output resp_s resp_o,

  output logic  credit_return_o
);

  word_t tag_mem_r  [0:tag_entries_c-1];
  word_t data_mem_r [0:num_test_word_c-1];

  logic     accept;
  logic     is_tag;
  logic     is_store;
  logic     is_load;
  tag_idx_t tag_idx;
  mem_idx_t data_idx;

  logic     resp_v_r;
  logic     credit_r;
  word_t    resp_data_r;

  // Nothing is taken while the stall input is high.
  assign accept     = req_v_i & ~stall_i;
  assign req_yumi_o = accept;

  assign is_tag   = req_i.addr[tag_space_bit_c];
  assign is_store = (req_i.op == op_store_c);
  assign is_load  = (req_i.op == op_load_c);

  // Tag entries sit one per block above the word offset.
  assign tag_idx  = req_i.addr[lg_block_words_c +: $bits(tag_idx_t)];
  assign data_idx = req_i.addr[lg_num_test_word_c-1:0];

  always_ff @(posedge clk_i) begin
    if (accept & is_store) begin
      if (is_tag) begin
        tag_mem_r[tag_idx] <= req_i.payload;
      end else begin
        data_mem_r[data_idx] <= req_i.payload;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept & is_load) begin
      resp_data_r <= is_tag ? tag_mem_r[tag_idx] : data_mem_r[data_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
      credit_r <= 1'b0;
    end else begin
      resp_v_r <= accept & is_load;
      credit_r <= accept; // One credit back per accepted request.
    end
  end

  assign resp_v_o        = resp_v_r;
  assign resp_o.data     = resp_data_r;
  assign credit_return_o = credit_r;

endmodule

// ==== design/test_node_master.sv ====
// ============================
// Test traffic master. Writes and reads back the tag array, then stores
// and loads test words, and flags any data word that comes back wrong.
// ============================

module test_node_master
  import cache_test_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,

  output logic  out_v_o,
  output req_s  out_req_o,
  input  logic  out_ready_i,

  input  logic  returned_v_i,
  input  word_t returned_data_i,
  output logic  returned_yumi_o,

  output logic  resp_v_o,
  output word_t resp_data_o,

  output logic  mismatch_o,
  output logic  done_o
);

  localparam word_t data_base_lp = word_t'(node_id_c) << lg_num_test_word_c;
  localparam word_t tag_base_lp  = word_t'(tag_offset_c);

  typedef enum logic [2:0] {
    STORE_TAG,
    LOAD_TAG,
    STORE_DATA,
    LOAD_DATA,
    SEND_DONE
  } send_state_e;

  typedef enum logic [1:0] {
    RECV_TAG,
    RECV_DATA,
    RECV_DONE
  } recv_state_e;

  send_state_e send_state_r, send_state_n;
  recv_state_e recv_state_r, recv_state_n;

  tag_idx_t send_tag_cnt_r;
  mem_idx_t send_mem_cnt_r;
  tag_idx_t recv_tag_cnt_r;
  mem_idx_t recv_mem_cnt_r;

  logic  out_xfer;
  logic  tag_last;
  logic  mem_last;
  logic  resp_v_r;
  word_t resp_data_r;
  logic  mismatch_r;
  logic  done_r;

  assign out_v_o  = (send_state_r != SEND_DONE);
  assign out_xfer = out_v_o & out_ready_i;
  assign tag_last = (send_tag_cnt_r == tag_idx_t'(tag_entries_c - 1));
  assign mem_last = (send_mem_cnt_r == mem_idx_t'(num_test_word_c - 1));

  // Request fields follow the current phase and counter.
  always_comb begin
    out_req_o      = '0;
    send_state_n   = send_state_r;
    case (send_state_r)
      STORE_TAG, LOAD_TAG: begin
        out_req_o.op = (send_state_r == STORE_TAG) ? op_store_c : op_load_c;
        out_req_o.addr[tag_space_bit_c] = 1'b1;
        out_req_o.addr[lg_block_words_c +: $bits(tag_idx_t)] = send_tag_cnt_r;
        if (send_state_r == STORE_TAG) begin
          out_req_o.payload = tag_base_lp + word_t'(send_tag_cnt_r);
        end
        if (out_xfer & tag_last) begin
          send_state_n = (send_state_r == STORE_TAG) ? LOAD_TAG : STORE_DATA;
        end
      end
      STORE_DATA, LOAD_DATA: begin
        out_req_o.op   = (send_state_r == STORE_DATA) ? op_store_c : op_load_c;
        out_req_o.addr = addr_t'(send_mem_cnt_r);
        if (send_state_r == STORE_DATA) begin
          out_req_o.payload = data_base_lp + word_t'(send_mem_cnt_r);
        end
        if (out_xfer & mem_last) begin
          send_state_n = (send_state_r == STORE_DATA) ? LOAD_DATA : SEND_DONE;
        end
      end
      default: send_state_n = SEND_DONE;
    endcase
  end

  always_comb begin
    recv_state_n = recv_state_r;
    if (returned_v_i) begin
      if ((recv_state_r == RECV_TAG) &&
          (recv_tag_cnt_r == tag_idx_t'(tag_entries_c - 1))) begin
        recv_state_n = RECV_DATA;
      end
      if ((recv_state_r == RECV_DATA) &&
          (recv_mem_cnt_r == mem_idx_t'(num_test_word_c - 1))) begin
        recv_state_n = RECV_DONE;
      end
    end
  end

  assign returned_yumi_o = returned_v_i; // Every response is taken at once.

  always_ff @(posedge clk_i) begin
    resp_data_r <= returned_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r   <= STORE_TAG;
      recv_state_r   <= RECV_TAG;
      send_tag_cnt_r <= '0;
      send_mem_cnt_r <= '0;
      recv_tag_cnt_r <= '0;
      recv_mem_cnt_r <= '0;
      resp_v_r       <= 1'b0;
      mismatch_r     <= 1'b0;
      done_r         <= 1'b0;
    end else begin
      send_state_r <= send_state_n;
      recv_state_r <= recv_state_n;
      resp_v_r     <= returned_v_i;
      done_r       <= (send_state_n == SEND_DONE) & (recv_state_n == RECV_DONE);
      if (out_xfer & ((send_state_r == STORE_TAG) | (send_state_r == LOAD_TAG))) begin
        send_tag_cnt_r <= send_tag_cnt_r + 1'b1; // Wraps to zero for the next phase.
      end
      if (out_xfer & ((send_state_r == STORE_DATA) | (send_state_r == LOAD_DATA))) begin
        send_mem_cnt_r <= send_mem_cnt_r + 1'b1;
      end
      if (returned_v_i & (recv_state_r == RECV_TAG)) begin
        recv_tag_cnt_r <= recv_tag_cnt_r + 1'b1;
      end
      if (returned_v_i & (recv_state_r == RECV_DATA)) begin
        recv_mem_cnt_r <= recv_mem_cnt_r + 1'b1;
        if (returned_data_i != data_base_lp + word_t'(recv_mem_cnt_r)) begin
          mismatch_r <= 1'b1; // Sticky until reset.
        end
      end
    end
  end

  assign resp_v_o    = resp_v_r;
  assign resp_data_o = resp_data_r;
  assign mismatch_o  = mismatch_r;
  assign done_o      = done_r;

endmodule

// ==== design/cache_test_top.sv ====
// ============================
// Top level of the test node. The stall input throttles the slave.
// ============================

module cache_test_top
  import cache_test_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,

  input  logic  slave_stall_i,

  output logic  resp_v_o,
  output word_t resp_data_o,

  output logic  mismatch_o,
  output logic  done_o
);

  logic  out_v;
  req_s  out_req;
  logic  out_ready;
  logic  returned_v;
  word_t returned_data;
  logic  returned_yumi;
  logic  req_v;
  req_s  req;
  logic  req_yumi;
  logic  resp_v;
  resp_s resp;
  logic  credit_return;

  test_node_master master (
    .clk_i(clk_i), .reset_i(reset_i),
    .out_v_o(out_v), .out_req_o(out_req), .out_ready_i(out_ready),
    .returned_v_i(returned_v), .returned_data_i(returned_data),
    .returned_yumi_o(returned_yumi),
    .resp_v_o(resp_v_o), .resp_data_o(resp_data_o),
    .mismatch_o(mismatch_o), .done_o(done_o)
  );

  link_endpoint endpoint (
    .clk_i(clk_i), .reset_i(reset_i),
    .out_v_i(out_v), .out_req_i(out_req), .out_ready_o(out_ready),
    .returned_v_o(returned_v), .returned_data_o(returned_data),
    .returned_yumi_i(returned_yumi),
    .req_v_o(req_v), .req_o(req), .req_yumi_i(req_yumi),
    .resp_v_i(resp_v), .resp_i(resp), .credit_return_i(credit_return)
  );

  tag_data_mem_slave slave (
    .clk_i(clk_i), .reset_i(reset_i),
    .stall_i(slave_stall_i),
    .req_v_i(req_v), .req_i(req), .req_yumi_o(req_yumi),
    .resp_v_o(resp_v), .resp_o(resp),
    .credit_return_o(credit_return)
  );

endmodule

// ==== tb/cache_test_tb.sv ====
// ============================
// Self-checking testbench for the cache test node. Applies a table of
// random stall densities and checks every response, done and mismatch.
// ============================

module cache_test_tb
  import cache_test_pkg::*;
();

  localparam int timeout_cycles_c = num_responses_c * 40 + 200;
  localparam int tail_cycles_c    = 50;

  typedef struct packed {
    int stall_bits; // More LFSR bits ANDed into one stall mean fewer stalls.
    int exp_resp;   // Responses expected while this row is active.
    int min_cycles; // Row stays active at least this long.
  } row_t;

  logic  clk_i;
  logic  reset_i;
  logic  slave_stall_i;
  logic  resp_v_o;
  word_t resp_data_o;
  logic  mismatch_o;
  logic  done_o;

  row_t        rows [0:3];
  word_t       exp_data [0:num_responses_c-1];
  logic [31:0] lfsr;
  int          resp_count;

  cache_test_top UUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .slave_stall_i(slave_stall_i),
    .resp_v_o     (resp_v_o),
    .resp_data_o  (resp_data_o),
    .mismatch_o   (mismatch_o),
    .done_o       (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  task automatic draw_stall(input int bits, output logic stall);
    stall = 1'b1;
    for (int i = 0; i < bits; i++) begin
      lfsr  = lfsr_next(lfsr);
      stall = stall & lfsr[0];
    end
  endtask

  task automatic build_expected();
    for (int t = 0; t < tag_entries_c; t++) begin
      exp_data[t] = word_t'(t + tag_offset_c);
    end
    for (int w = 0; w < num_test_word_c; w++) begin
      exp_data[tag_entries_c + w] = word_t'(w + (node_id_c << lg_num_test_word_c));
    end
  endtask

  task automatic stop_run();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic report_failure(input string why);
    $display("ERROR at %0t: %s", $time, why);
    stop_run();
  endtask

  task automatic check_word(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      stop_run();
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, actual, expected);
      stop_run();
    end
  endtask

  // Called once per cycle at the falling edge, where outputs are settled.
  task automatic sample_outputs();
    if (resp_v_o === 1'b1) begin
      if (resp_count >= num_responses_c) begin
        report_failure("a response appeared after all expected responses were seen");
      end
      check_word(resp_data_o, exp_data[resp_count],
                 $sformatf("response %0d data", resp_count));
      resp_count++;
    end else begin
      check_flag(resp_v_o, 1'b0, "resp_v_o level");
    end
    check_flag(mismatch_o, 1'b0, "mismatch flag");
    check_flag(done_o, logic'(resp_count == num_responses_c), "done flag");
  endtask

  initial begin
    repeat (timeout_cycles_c) @(posedge clk_i);
    $display("Timeout: the test did not finish within %0d cycles.", timeout_cycles_c);
    stop_run();
  end

  initial begin
    int   cum_target;
    int   row_cycles;
    logic stall;

    reset_i       = 1'b1;
    slave_stall_i = 1'b0;
    lfsr          = 32'hec26;
    resp_count    = 0;
    cum_target    = 0;

    rows[0] = '{3, 0, 12};  // Light stalls over the tag stores.
    rows[1] = '{1, 8, 0};   // Tag loads under heavy stalls.
    rows[2] = '{2, 0, 20};  // Data stores.
    rows[3] = '{1, 16, 0};  // Data loads under heavy stalls.
    build_expected();

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_flag(resp_v_o, 1'b0, "resp_v_o after reset");
    check_flag(done_o, 1'b0, "done_o after reset");
    check_flag(mismatch_o, 1'b0, "mismatch_o after reset");
    reset_i = 1'b0;

    for (int r = 0; r < 4; r++) begin
      cum_target += rows[r].exp_resp;
      row_cycles  = 0;
      while ((resp_count < cum_target) || (row_cycles < rows[r].min_cycles)) begin
        draw_stall(rows[r].stall_bits, stall);
        slave_stall_i = stall;
        @(negedge clk_i);
        row_cycles++;
        sample_outputs();
      end
    end

    // Traffic is over, so nothing else may come back.
    slave_stall_i = 1'b0;
    repeat (tail_cycles_c) begin
      @(negedge clk_i);
      sample_outputs();
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== flist.f ====
design/cache_test_pkg.sv
design/small_fifo.sv
design/link_endpoint.sv
design/tag_data_mem_slave.sv
design/test_node_master.sv
design/cache_test_top.sv
tb/cache_test_tb.sv

// ==== Bender.yml ====
package:
  name: cache_test

sources:
  - design/cache_test_pkg.sv
  - design/small_fifo.sv
  - design/link_endpoint.sv
  - design/tag_data_mem_slave.sv
  - design/test_node_master.sv
  - design/cache_test_top.sv
  - target: test
    files:
      - tb/cache_test_tb.sv
